// ==== Bender.yml ====
package:
  name: enc_pipe_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/enc_pos_pkg.sv
      - hdl/enc_sched_pkg.sv
      - hdl/pipe_sched_fsm.sv
      - hdl/lcu_scan_counter.sv
      - hdl/stage_pos_pipe.sv
      - hdl/stage_done_tracker.sv
      - hdl/enc_pipe_ctrl.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/enc_pipe_ctrl_assertions.sv
      - testbench/tb_enc_pipe_ctrl.sv

// ==== hdl/enc_ctrl_config.svh ====
//------------------------------------------------
// width and size macros of the encoder pipeline
// controller, included by the packages
//------------------------------------------------

`ifndef ENC_CTRL_CONFIG_SVH
`define ENC_CTRL_CONFIG_SVH

// lcu column and row index widths
`define PIC_X_WIDTH 8
`define PIC_Y_WIDTH 8

// quantization parameter
`define QP_WIDTH 6

// pre_l, pre_i, intra, db, ec
`define NUM_STAGES 5

`endif

// ==== hdl/enc_pipe_ctrl.sv ====
//------------------------------------------------
// pipeline controller of the intra encoder core;
// start a frame with start_i in idle, done_o goes
// high again once the last lcu has left ec
//------------------------------------------------

`timescale 1ns/1ns

module enc_pipe_ctrl
  import enc_pos_pkg::*;
  import enc_sched_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  lcu_x_t      x_total_i,
  input  lcu_y_t      y_total_i,
  input  qp_t         qp_i,
  output logic        done_o,
  output stage_mask_t stage_start_o,
  input  logic        pre_l_done_i,
  input  logic        pre_i_done_i,
  input  logic        intra_done_i,
  input  logic        db_done_i,
  input  logic        ec_done_i,
  output lcu_x_t      pre_l_x_o,
  output lcu_y_t      pre_l_y_o,
  output qp_t         pre_l_qp_o,
  output lcu_x_t      pre_i_x_o,
  output lcu_y_t      pre_i_y_o,
  output qp_t         pre_i_qp_o,
  output lcu_x_t      intra_x_o,
  output lcu_y_t      intra_y_o,
  output qp_t         intra_qp_o,
  output lcu_x_t      db_x_o,
  output lcu_y_t      db_y_o,
  output qp_t         db_qp_o,
  output lcu_x_t      ec_x_o,
  output lcu_y_t      ec_y_o,
  output qp_t         ec_qp_o
);

  logic        launch;
  logic        idle;
  logic        round_done;
  logic        all_issued;
  stage_mask_t active_mask;
  stage_mask_t stage_done;
  lcu_x_t      cur_x;
  lcu_y_t      cur_y;

  // pre_l done is the fetch done
  assign stage_done[STG_PRE_L] = pre_l_done_i;
  assign stage_done[STG_PRE_I] = pre_i_done_i;
  assign stage_done[STG_INTRA] = intra_done_i;
  assign stage_done[STG_DB]    = db_done_i;
  assign stage_done[STG_EC]    = ec_done_i;

  assign done_o = idle;

  pipe_sched_fsm u_pipe_sched_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .round_done_i (round_done),
    .all_issued_i (all_issued),
    .launch_o     (launch),
    .active_mask_o(active_mask),
    .idle_o       (idle)
  );

  lcu_scan_counter u_lcu_scan_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .idle_i      (idle),
    .launch_i    (launch),
    .x_total_i   (x_total_i),
    .y_total_i   (y_total_i),
    .x_o         (cur_x),
    .y_o         (cur_y),
    .all_issued_o(all_issued)
  );

  stage_pos_pipe u_stage_pos_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .launch_i  (launch),
    .x_i       (cur_x),
    .y_i       (cur_y),
    .qp_i      (qp_i),
    .pre_l_x_o (pre_l_x_o),
    .pre_l_y_o (pre_l_y_o),
    .pre_l_qp_o(pre_l_qp_o),
    .pre_i_x_o (pre_i_x_o),
    .pre_i_y_o (pre_i_y_o),
    .pre_i_qp_o(pre_i_qp_o),
    .intra_x_o (intra_x_o),
    .intra_y_o (intra_y_o),
    .intra_qp_o(intra_qp_o),
    .db_x_o    (db_x_o),
    .db_y_o    (db_y_o),
    .db_qp_o   (db_qp_o),
    .ec_x_o    (ec_x_o),
    .ec_y_o    (ec_y_o),
    .ec_qp_o   (ec_qp_o)
  );

  stage_done_tracker u_stage_done_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .launch_i     (launch),
    .active_mask_i(active_mask),
    .idle_i       (idle),
    .stage_done_i (stage_done),
    .stage_start_o(stage_start_o),
    .round_done_o (round_done)
  );

endmodule

// ==== hdl/enc_pos_pkg.sv ====
//------------------------------------------------
// lcu position and qp types shared by the scan
// counter and the per-stage position registers
//------------------------------------------------

`include "enc_ctrl_config.svh"

package enc_pos_pkg;

  // lcu column and row
  typedef logic [`PIC_X_WIDTH-1:0] lcu_x_t;
  typedef logic [`PIC_Y_WIDTH-1:0] lcu_y_t;

  // quantization parameter
  typedef logic [`QP_WIDTH-1:0] qp_t;

endpackage

// ==== hdl/enc_sched_pkg.sv ====
//------------------------------------------------
// scheduler state encoding, stage mask type and
// the bit position of each stage inside the mask
//------------------------------------------------

`include "enc_ctrl_config.svh"

package enc_sched_pkg;

  typedef enum logic [3:0] {
    S_IDLE, S_FILL0, S_FILL1, S_FILL2, S_FILL3,
    S_STEADY,
    S_DRAIN0, S_DRAIN1, S_DRAIN2, S_DRAIN3
  } sched_state_e;

  // one bit per stage
  typedef logic [`NUM_STAGES-1:0] stage_mask_t;

  localparam int STG_PRE_L = 0;
  localparam int STG_PRE_I = 1;
  localparam int STG_INTRA = 2;
  localparam int STG_DB    = 3;
  localparam int STG_EC    = 4;

endpackage

// ==== hdl/lcu_scan_counter.sv ====
//------------------------------------------------
// raster position of the next lcu to issue; moves
// on each launch until the last lcu has gone out
//------------------------------------------------

`timescale 1ns/1ns

module lcu_scan_counter
  import enc_pos_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   idle_i,
  input  logic   launch_i,
  input  lcu_x_t x_total_i,
  input  lcu_y_t y_total_i,
  output lcu_x_t x_o,
  output lcu_y_t y_o,
  output logic   all_issued_o
);

  logic issue;
  logic last;

  // drain launches issue nothing; a launch out of idle always does
  assign issue = launch_i && (idle_i || !all_issued_o);
  assign last  = (x_o == x_total_i) && (y_o == y_total_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_o          <= '0;
      y_o          <= '0;
      all_issued_o <= 1'b0;
    end else if (issue) begin
      all_issued_o <= last;
      if (x_o == x_total_i) begin
        x_o <= '0;
        y_o <= (y_o == y_total_i) ? '0 : lcu_y_t'(y_o + 1'b1);
      end else begin
        x_o <= x_o + 1'b1;
      end
    end else if (idle_i) begin
      x_o          <= '0;
      y_o          <= '0;
      all_issued_o <= 1'b0;
    end
  end

endmodule

// ==== hdl/pipe_sched_fsm.sv ====
//------------------------------------------------
// fill/steady/drain scheduler of the five stage
// pipeline; decides every round launch and gives
// the stages that take part in the current round
//------------------------------------------------

`timescale 1ns/1ns

module pipe_sched_fsm
  import enc_sched_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  logic        round_done_i,
  input  logic        all_issued_i,
  output logic        launch_o,
  output stage_mask_t active_mask_o,
  output logic        idle_o
);

  sched_state_e state_q;
  sched_state_e state_d;

  assign idle_o = (state_q == S_IDLE);

  // no new round after the last drain round
  assign launch_o = idle_o ? start_i : (round_done_i && (state_q != S_DRAIN3));

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (launch_o) state_d = S_FILL0;
      S_FILL0:  if (launch_o) state_d = S_FILL1;
      S_FILL1:  if (launch_o) state_d = S_FILL2;
      S_FILL2:  if (launch_o) state_d = S_FILL3;
      S_FILL3:  if (launch_o) state_d = S_STEADY;
      S_STEADY: if (launch_o && all_issued_i) state_d = S_DRAIN0;
      S_DRAIN0: if (launch_o) state_d = S_DRAIN1;
      S_DRAIN1: if (launch_o) state_d = S_DRAIN2;
      S_DRAIN2: if (launch_o) state_d = S_DRAIN3;
      S_DRAIN3: if (round_done_i) state_d = S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // bit 0 is pre_l, bit 4 is ec
  always_comb begin
    case (state_q)
      S_FILL0:  active_mask_o = 5'b00001;
      S_FILL1:  active_mask_o = 5'b00011;
      S_FILL2:  active_mask_o = 5'b00111;
      S_FILL3:  active_mask_o = 5'b01111;
      S_STEADY: active_mask_o = 5'b11111;
      S_DRAIN0: active_mask_o = 5'b11110;
      S_DRAIN1: active_mask_o = 5'b11100;
      S_DRAIN2: active_mask_o = 5'b11000;
      S_DRAIN3: active_mask_o = 5'b10000;
      default:  active_mask_o = '0;
    endcase
  end

endmodule

// ==== hdl/stage_done_tracker.sv ====
//------------------------------------------------
// issues the stage start pulses of a round and
// collects the done reports until the round closes
//------------------------------------------------

`timescale 1ns/1ns

module stage_done_tracker
  import enc_sched_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        launch_i,
  input  stage_mask_t active_mask_i,
  input  logic        idle_i,
  input  stage_mask_t stage_done_i,
  output stage_mask_t stage_start_o,
  output logic        round_done_o
);

  logic        launch_q;
  stage_mask_t done_flags;

  //------------------------------------------------
  // start pulses
  //------------------------------------------------

  // state has stepped by now, so the mask is the new round's
  assign stage_start_o = launch_q ? active_mask_i : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      launch_q <= 1'b0;
    end else begin
      launch_q <= launch_i;
    end
  end

  //------------------------------------------------
  // done collection
  //------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_flags <= '0;
    end else if (idle_i || round_done_o) begin
      done_flags <= '0;
    end else begin
      done_flags <= done_flags | (stage_done_i & active_mask_i);
    end
  end

  // single cycle, flags still full while it is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      round_done_o <= 1'b0;
    end else begin
      round_done_o <= !idle_i && !round_done_o && (done_flags == active_mask_i);
    end
  end

endmodule

// ==== hdl/stage_pos_pipe.sv ====
//------------------------------------------------
// per-stage lcu position and qp; each launch moves
// every slot one stage down the pipeline
//------------------------------------------------

`timescale 1ns/1ns

`include "enc_ctrl_config.svh"

module stage_pos_pipe
  import enc_pos_pkg::*;
  import enc_sched_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   launch_i,
  input  lcu_x_t x_i,
  input  lcu_y_t y_i,
  input  qp_t    qp_i,
  output lcu_x_t pre_l_x_o,
  output lcu_y_t pre_l_y_o,
  output qp_t    pre_l_qp_o,
  output lcu_x_t pre_i_x_o,
  output lcu_y_t pre_i_y_o,
  output qp_t    pre_i_qp_o,
  output lcu_x_t intra_x_o,
  output lcu_y_t intra_y_o,
  output qp_t    intra_qp_o,
  output lcu_x_t db_x_o,
  output lcu_y_t db_y_o,
  output qp_t    db_qp_o,
  output lcu_x_t ec_x_o,
  output lcu_y_t ec_y_o,
  output qp_t    ec_qp_o
);

  lcu_x_t slot_x  [`NUM_STAGES];
  lcu_y_t slot_y  [`NUM_STAGES];
  qp_t    slot_qp [`NUM_STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_STAGES; i++) begin
        slot_x[i]  <= '0;
        slot_y[i]  <= '0;
        slot_qp[i] <= '0;
      end
    end else if (launch_i) begin
      slot_x[STG_PRE_L]  <= x_i;
      slot_y[STG_PRE_L]  <= y_i;
      slot_qp[STG_PRE_L] <= qp_i;
      // later stages follow one round behind
      for (int i = 1; i < `NUM_STAGES; i++) begin
        slot_x[i]  <= slot_x[i-1];
        slot_y[i]  <= slot_y[i-1];
        slot_qp[i] <= slot_qp[i-1];
      end
    end
  end

  assign pre_l_x_o  = slot_x[STG_PRE_L];
  assign pre_l_y_o  = slot_y[STG_PRE_L];
  assign pre_l_qp_o = slot_qp[STG_PRE_L];
  assign pre_i_x_o  = slot_x[STG_PRE_I];
  assign pre_i_y_o  = slot_y[STG_PRE_I];
  assign pre_i_qp_o = slot_qp[STG_PRE_I];
  assign intra_x_o  = slot_x[STG_INTRA];
  assign intra_y_o  = slot_y[STG_INTRA];
  assign intra_qp_o = slot_qp[STG_INTRA];
  assign db_x_o     = slot_x[STG_DB];
  assign db_y_o     = slot_y[STG_DB];
  assign db_qp_o    = slot_qp[STG_DB];
  assign ec_x_o     = slot_x[STG_EC];
  assign ec_y_o     = slot_y[STG_EC];
  assign ec_qp_o    = slot_qp[STG_EC];

endmodule

// ==== testbench/enc_pipe_ctrl_assertions.sv ====
//------------------------------------------------
// protocol checks on the pipeline controller,
// bound to every instance of the top level
//------------------------------------------------

`timescale 1ns/1ns

module enc_pipe_ctrl_assertions
  import enc_sched_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        start_i,
  input logic        done_i,
  input stage_mask_t stage_start_i
);

  // nothing starts while the frame is done
  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> (stage_start_i == '0))
    else $error("stage start issued while done_o is high");

  a_start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (stage_start_i != '0) |=> (stage_start_i == '0))
    else $error("stage start held for more than one cycle");

  a_accept_start: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i && start_i) |=> !done_i)
    else $error("start_i in idle did not clear done_o");

  // only the fill, steady and drain patterns
  a_start_in_mask: assert property (@(posedge clk) disable iff (!rst_n)
    (stage_start_i == '0) ||
    (stage_start_i inside {5'b00001, 5'b00011, 5'b00111, 5'b01111, 5'b11111,
                           5'b11110, 5'b11100, 5'b11000, 5'b10000}))
    else $error("start bits outside the fill, steady and drain patterns");

endmodule

bind enc_pipe_ctrl enc_pipe_ctrl_assertions u_enc_pipe_ctrl_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .start_i      (start_i),
  .done_i       (done_o),
  .stage_start_i(stage_start_o)
);

// ==== testbench/enc_pipe_stimulus.txt ====
// x_total y_total qp max_delay, one frame per line, decimal
// totals are the last lcu column and row; every frame holds 5 or more lcus
4 0 26 0
2 1 30 3
3 2 12 6
1 2 40 2
6 3 51 10
0 4 8 1
7 1 63 4

// ==== testbench/tb_enc_pipe_ctrl.sv ====
//------------------------------------------------
// testbench of the encoder pipeline controller;
// frames come from the stimulus file and stage
// models answer each start after a random delay
//------------------------------------------------

`timescale 1ns/1ns

`include "enc_ctrl_config.svh"

module tb_enc_pipe_ctrl
  import enc_pos_pkg::*;
  import enc_sched_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int NS = `NUM_STAGES;
  localparam int XW = `PIC_X_WIDTH;
  localparam int YW = `PIC_Y_WIDTH;
  localparam int QW = `QP_WIDTH;

  logic        clk;
  logic        rst_n;
  logic        start_i;
  lcu_x_t      x_total;
  lcu_y_t      y_total;
  qp_t         qp_in;
  logic        done;
  stage_mask_t stage_start;
  stage_mask_t done_vec;

  wire [NS*XW-1:0] all_x;
  wire [NS*YW-1:0] all_y;
  wire [NS*QW-1:0] all_qp;

  string stage_names [NS] = '{"pre_l", "pre_i", "intra", "db", "ec"};

  // frames from the file
  int stim_xt[$];
  int stim_yt[$];
  int stim_qp[$];
  int stim_dly[$];

  // scoreboard state of the running frame
  int          cur_xt;
  int          cur_lcus;
  int          cur_qp;
  int          cur_delay;
  int          round_idx = 0;
  stage_mask_t pending = '0;
  stage_mask_t busy = '0;
  int          cnt [NS];
  longint      watchdog_ns = 0;

  int mask_errs = 0;
  int pos_errs = 0;
  int qp_errs = 0;
  int bit_errs = 0;
  int proto_errs = 0;

  enc_pipe_ctrl u_enc_pipe_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .x_total_i    (x_total),
    .y_total_i    (y_total),
    .qp_i         (qp_in),
    .done_o       (done),
    .stage_start_o(stage_start),
    .pre_l_done_i (done_vec[STG_PRE_L]),
    .pre_i_done_i (done_vec[STG_PRE_I]),
    .intra_done_i (done_vec[STG_INTRA]),
    .db_done_i    (done_vec[STG_DB]),
    .ec_done_i    (done_vec[STG_EC]),
    .pre_l_x_o    (all_x[STG_PRE_L*XW +: XW]),
    .pre_l_y_o    (all_y[STG_PRE_L*YW +: YW]),
    .pre_l_qp_o   (all_qp[STG_PRE_L*QW +: QW]),
    .pre_i_x_o    (all_x[STG_PRE_I*XW +: XW]),
    .pre_i_y_o    (all_y[STG_PRE_I*YW +: YW]),
    .pre_i_qp_o   (all_qp[STG_PRE_I*QW +: QW]),
    .intra_x_o    (all_x[STG_INTRA*XW +: XW]),
    .intra_y_o    (all_y[STG_INTRA*YW +: YW]),
    .intra_qp_o   (all_qp[STG_INTRA*QW +: QW]),
    .db_x_o       (all_x[STG_DB*XW +: XW]),
    .db_y_o       (all_y[STG_DB*YW +: YW]),
    .db_qp_o      (all_qp[STG_DB*QW +: QW]),
    .ec_x_o       (all_x[STG_EC*XW +: XW]),
    .ec_y_o       (all_y[STG_EC*YW +: YW]),
    .ec_qp_o      (all_qp[STG_EC*QW +: QW])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //------------------------------------------------
  // reference model and compare tasks
  //------------------------------------------------

  // fill adds one stage per round, drain drops the lowest
  function automatic stage_mask_t expected_mask(int r, int lcus);
    stage_mask_t full;
    stage_mask_t lo;
    stage_mask_t hi;
    full = '1;
    lo = (r < NS - 1) ? (full >> (NS - 1 - r)) : full;
    hi = (r >= lcus) ? (full << (r - lcus + 1)) : full;
    return lo & hi;
  endfunction

  // qp applied at the launch of round r
  function automatic qp_t qp_for(int r);
    return qp_t'(cur_qp + 5 * r);
  endfunction

  task automatic check_mask(string name, stage_mask_t exp, stage_mask_t act);
    if (act !== exp) begin
      mask_errs++;
      $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_pos(string name, lcu_x_t exp_x, lcu_y_t exp_y,
                           lcu_x_t act_x, lcu_y_t act_y);
    if (act_x !== exp_x || act_y !== exp_y) begin
      pos_errs++;
      $display("MISMATCH t=%0t %s_x_o/%s_y_o expected (%0d,%0d) actual (%0d,%0d)",
               $time, name, name, exp_x, exp_y, act_x, act_y);
    end
  endtask

  task automatic check_qp(string name, qp_t exp, qp_t act);
    if (act !== exp) begin
      qp_errs++;
      $display("MISMATCH t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic read_stimulus();
    int fd;
    int xt;
    int yt;
    int qp;
    int dly;
    logic [8*96-1:0] line;
    fd = $fopen("testbench/enc_pipe_stimulus.txt", "r");
    if (fd == 0) begin
      proto_errs++;
      $display("could not open the stimulus file");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%d %d %d %d", xt, yt, qp, dly) == 4) begin
        stim_xt.push_back(xt);
        stim_yt.push_back(yt);
        stim_qp.push_back(qp);
        stim_dly.push_back(dly);
      end
    end
    $fclose(fd);
  endtask

  //------------------------------------------------
  // stage responders and start pulse monitor
  //------------------------------------------------

  initial begin
    stage_mask_t fire;
    stage_mask_t exp_mask;
    int n;
    done_vec = '0;
    void'($urandom(68));
    forever begin
      @(negedge clk);
      fire = '0;
      for (int k = 0; k < NS; k++) begin
        if (busy[k]) begin
          if (cnt[k] == 0) begin
            fire[k]    = 1'b1;
            busy[k]    = 1'b0;
            pending[k] = 1'b0;
          end else begin
            cnt[k]--;
          end
        end
      end
      if (rst_n && stage_start != '0) begin
        exp_mask = expected_mask(round_idx, cur_lcus);
        check_mask("stage_start_o", exp_mask, stage_start);
        check_bit("done_o", 1'b0, done);
        if (pending != '0) begin
          proto_errs++;
          $display("t=%0t a start pulse came before every done of the last round", $time);
        end
        for (int k = 0; k < NS; k++) begin
          n = round_idx - k;
          if (exp_mask[k]) begin
            check_pos(stage_names[k], lcu_x_t'(n % (cur_xt + 1)),
                      lcu_y_t'(n / (cur_xt + 1)),
                      lcu_x_t'(all_x[k*XW +: XW]), lcu_y_t'(all_y[k*YW +: YW]));
            check_qp({stage_names[k], "_qp_o"}, qp_for(n), qp_t'(all_qp[k*QW +: QW]));
          end else if ($urandom_range(1, 0) == 1) begin
            // stray done from a stage outside the round
            fire[k] = 1'b1;
          end
        end
        busy    = stage_start;
        pending = stage_start;
        for (int k = 0; k < NS; k++) begin
          cnt[k] = $urandom_range(cur_delay, 0);
        end
        round_idx++;
        qp_in = qp_for(round_idx);
      end
      done_vec = fire;
    end
  end

  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("watchdog expired: the frames did not finish in the expected time");
    $display("Test failed");
    $finish;
  end

  //------------------------------------------------
  // frame sequence
  //------------------------------------------------

  initial begin
    int lcus;
    int total;
    longint budget;
    rst_n   = 1'b0;
    start_i = 1'b0;
    x_total = '0;
    y_total = '0;
    qp_in   = '0;
    read_stimulus();
    if (stim_xt.size() == 0) begin
      proto_errs++;
      $display("no frames found in the stimulus file");
    end
    budget = longint'(stim_xt.size() * 20 + 100) * CLK_PERIOD;
    foreach (stim_xt[f]) begin
      lcus = (stim_xt[f] + 1) * (stim_yt[f] + 1);
      budget += longint'(lcus + 4) * (stim_dly[f] + 8) * CLK_PERIOD;
    end
    watchdog_ns = budget;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("done_o", 1'b1, done);
    check_mask("stage_start_o", '0, stage_start);

    for (int f = 0; f < stim_xt.size(); f++) begin
      lcus = (stim_xt[f] + 1) * (stim_yt[f] + 1);
      if (lcus < 5) begin
        proto_errs++;
        $display("frame %0d has only %0d lcus and is skipped", f, lcus);
        continue;
      end
      cur_xt    = stim_xt[f];
      cur_lcus  = lcus;
      cur_qp    = stim_qp[f];
      cur_delay = stim_dly[f];
      round_idx = 0;
      x_total   = lcu_x_t'(stim_xt[f]);
      y_total   = lcu_y_t'(stim_yt[f]);
      qp_in     = qp_for(0);
      start_i   = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      check_bit("done_o", 1'b0, done);
      // a second start inside the frame must be ignored
      repeat (3) @(negedge clk);
      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      while (done !== 1'b1) @(negedge clk);
      if (round_idx != lcus + 4) begin
        proto_errs++;
        $display("frame %0d ended after %0d rounds instead of %0d", f, round_idx, lcus + 4);
      end
      if (pending != '0) begin
        proto_errs++;
        $display("frame %0d ended while a stage still owed its done", f);
      end
      repeat (2) @(negedge clk);
    end

    total = mask_errs + pos_errs + qp_errs + bit_errs + proto_errs;
    $display("errors: mask %0d, position %0d, qp %0d, bit %0d, protocol %0d",
             mask_errs, pos_errs, qp_errs, bit_errs, proto_errs);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/enc_pos_pkg.sv
hdl/enc_sched_pkg.sv
hdl/pipe_sched_fsm.sv
hdl/lcu_scan_counter.sv
hdl/stage_pos_pipe.sv
hdl/stage_done_tracker.sv
hdl/enc_pipe_ctrl.sv
testbench/enc_pipe_ctrl_assertions.sv
testbench/tb_enc_pipe_ctrl.sv
